//--- rtl/mat_ops_pkg.sv
package mat_ops_pkg;

	// datapath geometry
	localparam int word_len = 8;
	// words per sram row
	localparam int row_words = 4;
	localparam int addr_len = 8;

	// weight block read from sram a
	localparam int weight_rows = 4;
	// only the lower words of each weight row reach the core
	localparam int weight_keep = 3;

	// feature map rows from each of sram b and c
	localparam int fmap_rows = 2;

	// result chunks, half go to b and half to c
	localparam int out_chunks_per_sram = 2;
	localparam int chunk_words = 3;

	// base addresses in each sram
	localparam int read_a_offset = 0;
	localparam int read_b_offset = 16;
	localparam int read_c_offset = 16;
	localparam int write_b_offset = 32;
	localparam int write_c_offset = 32;

	// cycles between all reads done and core start
	localparam int settle_cycles = 4;

	// top level phases
	typedef enum logic [2:0] {
		ctrl_idle,
		ctrl_read,
		ctrl_core_run,
		ctrl_write,
		ctrl_done
	} ctrl_state_e;

	// shared by the row readers and row writers
	typedef enum logic [1:0] {
		buf_idle,
		buf_busy,
		buf_done
	} buf_state_e;

endpackage

//--- rtl/sram_row_reader.sv
`timescale 1ns/1ps

module sram_row_reader #(
	parameter int OFFSET = 0,
	parameter int ROWS = 4,
	parameter int KEEP = 3
) (
	input  logic                                                 i_clk,
	input  logic                                                 i_rstn,
	input  logic                                                 i_read_start,
	input  logic                                                 i_read_clear,
	input  logic [mat_ops_pkg::row_words*mat_ops_pkg::word_len-1:0] i_read_data,
	output logic [mat_ops_pkg::addr_len-1:0]                      o_read_addr,
	output logic [ROWS*KEEP*mat_ops_pkg::word_len-1:0]            o_buffer,
	output logic                                                 o_read_done
);
	import mat_ops_pkg::*;

	// counter must also hold ROWS once every row is issued
	localparam int ROW_W = $clog2(ROWS + 1);
	localparam int KEEP_W = KEEP * word_len;

	buf_state_e r_state;
	// next row to put on the address bus
	logic [ROW_W-1:0] r_row;
	// capture side, one cycle behind the address
	logic r_cap_vld;
	logic [ROW_W-1:0] r_cap_idx;
	// row 0 sits in the lowest words
	logic [ROWS-1:0][KEEP_W-1:0] r_buf;

	// idle shows the first row so the sram samples it on the start edge
	assign o_read_addr = addr_len'(OFFSET) + addr_len'(r_row);
	assign o_buffer = r_buf;
	assign o_read_done = (r_state == buf_done);

	always_ff @(posedge i_clk or negedge i_rstn) begin
		if (!i_rstn) begin
			r_state <= buf_idle;
			r_row <= '0;
			r_cap_vld <= 1'b0;
			r_cap_idx <= '0;
		end else if (i_read_clear) begin
			r_state <= buf_idle;
			r_row <= '0;
			r_cap_vld <= 1'b0;
		end else if (i_read_start) begin
			// row 0 already issued on this edge
			r_state <= buf_busy;
			r_row <= ROW_W'(1);
			r_cap_vld <= 1'b1;
			r_cap_idx <= '0;
		end else if (r_state == buf_busy) begin
			if (r_row < ROW_W'(ROWS)) begin
				r_row <= r_row + 1'b1;
				r_cap_vld <= 1'b1;
				r_cap_idx <= r_row;
			end else begin
				r_cap_vld <= 1'b0;
			end
			// last row lands this edge
			if (r_cap_vld && (r_cap_idx == ROW_W'(ROWS - 1)))
				r_state <= buf_done;
		end
	end

	// trim to the lower KEEP words of each row
	always_ff @(posedge i_clk) begin
		if (i_read_clear)
			r_buf <= '0;
		else if (r_cap_vld)
			r_buf[r_cap_idx] <= i_read_data[KEEP_W-1:0];
	end

endmodule

//--- rtl/sram_row_writer.sv
`timescale 1ns/1ps

module sram_row_writer #(
	parameter int OFFSET = 32,
	parameter int CHUNKS = 2
) (
	input  logic                                                   i_clk,
	input  logic                                                   i_rstn,
	input  logic                                                   i_write_start,
	input  logic [CHUNKS*mat_ops_pkg::chunk_words*mat_ops_pkg::word_len-1:0] i_chunks,
	input  logic [mat_ops_pkg::addr_len-1:0]                        i_read_addr,
	output logic [mat_ops_pkg::addr_len-1:0]                        o_addr,
	output logic                                                   o_wr_en,
	output logic [mat_ops_pkg::row_words*mat_ops_pkg::word_len-1:0] o_write_data,
	output logic                                                   o_write_done
);
	import mat_ops_pkg::*;

	localparam int CHUNK_W = chunk_words * word_len;
	// zero words above each chunk to fill a row
	localparam int PAD_W = (row_words - chunk_words) * word_len;
	localparam int IDX_W = (CHUNKS > 1) ? $clog2(CHUNKS) : 1;

	buf_state_e r_state;
	// chunk being written this cycle
	logic [IDX_W-1:0] r_idx;
	// results held from the core valid cycle
	logic [CHUNKS-1:0][CHUNK_W-1:0] r_chunks;

	// one row per cycle while busy
	assign o_wr_en = (r_state == buf_busy);
	assign o_write_done = (r_state == buf_done);

	// hand the port back to the reader when not writing
	assign o_addr = o_wr_en ? (addr_len'(OFFSET) + addr_len'(r_idx)) : i_read_addr;

	// chunk in the lower words, top word zero
	assign o_write_data = {{PAD_W{1'b0}}, r_chunks[r_idx]};

	always_ff @(posedge i_clk or negedge i_rstn) begin
		if (!i_rstn) begin
			r_state <= buf_idle;
			r_idx <= '0;
		end else if (i_write_start) begin
			// done drops here for the next job
			r_state <= buf_busy;
			r_idx <= '0;
		end else if (r_state == buf_busy) begin
			if (r_idx == IDX_W'(CHUNKS - 1))
				r_state <= buf_done;
			else
				r_idx <= r_idx + 1'b1;
		end
	end

	// capture the core output on its only valid cycle
	always_ff @(posedge i_clk) begin
		if (i_write_start)
			r_chunks <= i_chunks;
	end

endmodule

//--- rtl/mat_ops_ctrl.sv
`timescale 1ns/1ps

module mat_ops_ctrl #(
	parameter int SETTLE = 4
) (
	input  logic       i_clk,
	input  logic       i_rstn,
	input  logic       i_start,
	input  logic [2:0] i_read_done,
	input  logic [1:0] i_write_done,
	input  logic       i_core_valid,
	output logic       o_read_start,
	output logic       o_read_clear,
	output logic       o_core_start,
	output logic       o_write_start,
	output logic       o_done
);
	import mat_ops_pkg::*;

	ctrl_state_e r_state;
	ctrl_state_e w_next;
	// one-hot delay line after the last read
	logic [SETTLE-1:0] r_settle;
	logic w_reads_done;

	// all three readers hold done until clear
	assign w_reads_done = (r_state == ctrl_read) && (&i_read_done);

	always_ff @(posedge i_clk or negedge i_rstn) begin
		if (!i_rstn)
			r_state <= ctrl_idle;
		else
			r_state <= w_next;
	end

	// load once, then walk the bit out the top
	always_ff @(posedge i_clk or negedge i_rstn) begin
		if (!i_rstn)
			r_settle <= '0;
		else if (w_reads_done && (r_settle == '0))
			r_settle <= SETTLE'(1);
		else
			r_settle <= r_settle << 1;
	end

	always_comb begin
		w_next = r_state;
		case (r_state)
			// start ignored outside idle
			ctrl_idle: if (i_start) w_next = ctrl_read;
			// last settle stage ends the read phase
			ctrl_read: if (r_settle[SETTLE-1]) w_next = ctrl_core_run;
			// core latency is open ended
			ctrl_core_run: if (i_core_valid) w_next = ctrl_write;
			ctrl_write: if (&i_write_done) w_next = ctrl_done;
			// single cycle
			ctrl_done: w_next = ctrl_idle;
			default: w_next = ctrl_idle;
		endcase
	end

	// phase strobes, each one cycle on a phase change
	assign o_read_start = (r_state == ctrl_idle) && (w_next == ctrl_read);
	assign o_core_start = (r_state == ctrl_read) && (w_next == ctrl_core_run);
	assign o_write_start = (r_state == ctrl_core_run) && (w_next == ctrl_write);
	// buffers emptied while done is shown
	assign o_read_clear = (r_state == ctrl_done);
	assign o_done = (r_state == ctrl_done);

endmodule

//--- rtl/mat_ops.sv
`timescale 1ns/1ps

module mat_ops (
	input  logic i_clk,
	input  logic i_rstn,
	input  logic i_start,
	// sram a, read only
	input  logic [mat_ops_pkg::row_words*mat_ops_pkg::word_len-1:0] i_read_data_a,
	output logic [mat_ops_pkg::addr_len-1:0]                        o_addr_a,
	// sram b
	input  logic [mat_ops_pkg::row_words*mat_ops_pkg::word_len-1:0] i_read_data_b,
	output logic [mat_ops_pkg::addr_len-1:0]                        o_addr_b,
	output logic                                                   o_wr_en_b,
	output logic [mat_ops_pkg::row_words*mat_ops_pkg::word_len-1:0] o_write_data_b,
	// sram c
	input  logic [mat_ops_pkg::row_words*mat_ops_pkg::word_len-1:0] i_read_data_c,
	output logic [mat_ops_pkg::addr_len-1:0]                        o_addr_c,
	output logic                                                   o_wr_en_c,
	output logic [mat_ops_pkg::row_words*mat_ops_pkg::word_len-1:0] o_write_data_c,
	// external convolution core
	output logic o_core_start,
	output logic [mat_ops_pkg::weight_rows*mat_ops_pkg::weight_keep*mat_ops_pkg::word_len-1:0]
		o_core_weight,
	output logic [2*mat_ops_pkg::fmap_rows*mat_ops_pkg::row_words*mat_ops_pkg::word_len-1:0]
		o_core_fmap,
	input  logic i_core_valid,
	input  logic [2*mat_ops_pkg::out_chunks_per_sram*mat_ops_pkg::chunk_words*
		mat_ops_pkg::word_len-1:0] i_core_fmap,
	output logic o_done
);
	import mat_ops_pkg::*;

	// result bits per destination sram
	localparam int HALF_W = out_chunks_per_sram * chunk_words * word_len;
	localparam int FMAP_W = fmap_rows * row_words * word_len;

	logic w_read_start;
	logic w_read_clear;
	logic w_write_start;
	// {c, b, a}
	logic [2:0] w_read_done;
	// {c, b}
	logic [1:0] w_write_done;
	// reader addresses for the shared b and c ports
	logic [addr_len-1:0] w_read_addr_b;
	logic [addr_len-1:0] w_read_addr_c;
	logic [FMAP_W-1:0] w_buf_b;
	logic [FMAP_W-1:0] w_buf_c;

	// b in the upper half, c in the lower half
	assign o_core_fmap = {w_buf_b, w_buf_c};

	mat_ops_ctrl #(.SETTLE(settle_cycles)) u_ctrl (
		.i_clk         (i_clk),
		.i_rstn        (i_rstn),
		.i_start       (i_start),
		.i_read_done   (w_read_done),
		.i_write_done  (w_write_done),
		.i_core_valid  (i_core_valid),
		.o_read_start  (w_read_start),
		.o_read_clear  (w_read_clear),
		.o_core_start  (o_core_start),
		.o_write_start (w_write_start),
		.o_done        (o_done)
	);

	// weights, trimmed per row
	sram_row_reader #(.OFFSET(read_a_offset), .ROWS(weight_rows), .KEEP(weight_keep)) u_read_a (
		.i_clk        (i_clk),
		.i_rstn       (i_rstn),
		.i_read_start (w_read_start),
		.i_read_clear (w_read_clear),
		.i_read_data  (i_read_data_a),
		.o_read_addr  (o_addr_a),
		.o_buffer     (o_core_weight),
		.o_read_done  (w_read_done[0])
	);

	// full rows for both feature maps
	sram_row_reader #(.OFFSET(read_b_offset), .ROWS(fmap_rows), .KEEP(row_words)) u_read_b (
		.i_clk        (i_clk),
		.i_rstn       (i_rstn),
		.i_read_start (w_read_start),
		.i_read_clear (w_read_clear),
		.i_read_data  (i_read_data_b),
		.o_read_addr  (w_read_addr_b),
		.o_buffer     (w_buf_b),
		.o_read_done  (w_read_done[1])
	);

	sram_row_reader #(.OFFSET(read_c_offset), .ROWS(fmap_rows), .KEEP(row_words)) u_read_c (
		.i_clk        (i_clk),
		.i_rstn       (i_rstn),
		.i_read_start (w_read_start),
		.i_read_clear (w_read_clear),
		.i_read_data  (i_read_data_c),
		.o_read_addr  (w_read_addr_c),
		.o_buffer     (w_buf_c),
		.o_read_done  (w_read_done[2])
	);

	// chunks 0 and 1 back to b
	sram_row_writer #(.OFFSET(write_b_offset), .CHUNKS(out_chunks_per_sram)) u_write_b (
		.i_clk         (i_clk),
		.i_rstn        (i_rstn),
		.i_write_start (w_write_start),
		.i_chunks      (i_core_fmap[HALF_W-1:0]),
		.i_read_addr   (w_read_addr_b),
		.o_addr        (o_addr_b),
		.o_wr_en       (o_wr_en_b),
		.o_write_data  (o_write_data_b),
		.o_write_done  (w_write_done[0])
	);

	// chunks 2 and 3 to c
	sram_row_writer #(.OFFSET(write_c_offset), .CHUNKS(out_chunks_per_sram)) u_write_c (
		.i_clk         (i_clk),
		.i_rstn        (i_rstn),
		.i_write_start (w_write_start),
		.i_chunks      (i_core_fmap[2*HALF_W-1:HALF_W]),
		.i_read_addr   (w_read_addr_c),
		.o_addr        (o_addr_c),
		.o_wr_en       (o_wr_en_c),
		.o_write_data  (o_write_data_c),
		.o_write_done  (w_write_done[1])
	);

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD = 20,
	parameter int RESET_CYCLES = 8
) (
	output logic o_clk,
	output logic o_rstn
);
	initial begin
		o_clk = 1'b0;
		forever #(PERIOD / 2) o_clk = ~o_clk;
	end

	// reset drops on a falling edge like every other input
	initial begin
		o_rstn = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clk);
		@(negedge o_clk);
		o_rstn = 1'b1;
	end

endmodule

//--- bench/mat_ops_checker.sv
`timescale 1ns/1ps

module mat_ops_checker (
	input logic i_clk,
	input logic i_rstn,
	input logic i_done,
	input logic i_core_start,
	input logic i_wr_en_b,
	input logic i_wr_en_c
);
	// failure tallies, summed by the testbench at the end
	int n_done_fail = 0;
	int n_wr_fail = 0;
	int n_start_fail = 0;

	// done phase lasts one cycle only
	done_single: assert property (@(posedge i_clk) disable iff (!i_rstn) i_done |=> !i_done)
	else begin
		n_done_fail++;
		$error("o_done held high for two cycles");
	end

	// both writers run off the same write_start
	wr_en_pair: assert property (@(posedge i_clk) disable iff (!i_rstn) i_wr_en_b == i_wr_en_c)
	else begin
		n_wr_fail++;
		$error("o_wr_en_b and o_wr_en_c differ");
	end

	// core start belongs to the read side, no writes yet
	start_no_wr: assert property (@(posedge i_clk) disable iff (!i_rstn)
		i_core_start |-> !(i_wr_en_b || i_wr_en_c))
	else begin
		n_start_fail++;
		$error("write enable high with o_core_start");
	end

endmodule

bind mat_ops mat_ops_checker u_checker (
	.i_clk        (i_clk),
	.i_rstn       (i_rstn),
	.i_done       (o_done),
	.i_core_start (o_core_start),
	.i_wr_en_b    (o_wr_en_b),
	.i_wr_en_c    (o_wr_en_c)
);

//--- bench/mat_ops_tb.sv
`timescale 1ns/1ps

module mat_ops_tb;
	import mat_ops_pkg::*;

	localparam int JOBS = 20;
	localparam int JOB_CYCLES = 40;
	localparam int RESET_CYCLES = 8;
	localparam int CYCLE_LIMIT = JOBS * JOB_CYCLES + RESET_CYCLES;
	localparam int DEPTH = 1 << addr_len;
	localparam int ROW_BITS = row_words * word_len;
	localparam int KEEP_BITS = weight_keep * word_len;
	localparam int CHUNK_BITS = chunk_words * word_len;
	localparam int WEIGHT_BITS = weight_rows * KEEP_BITS;
	localparam int BUF_BITS = fmap_rows * ROW_BITS;
	localparam int RESULT_BITS = 2 * out_chunks_per_sram * CHUNK_BITS;
	// reads done rows+1 cycles in, then the settle line
	localparam int START_TO_CORE = weight_rows + 1 + settle_cycles;
	// write start, one write per chunk, write_done, then done
	localparam int VALID_TO_DONE = 1 + out_chunks_per_sram + 1;

	logic i_clk;
	logic i_rstn;
	logic i_start;
	logic [ROW_BITS-1:0] i_read_data_a;
	logic [ROW_BITS-1:0] i_read_data_b;
	logic [ROW_BITS-1:0] i_read_data_c;
	logic [addr_len-1:0] o_addr_a;
	logic [addr_len-1:0] o_addr_b;
	logic [addr_len-1:0] o_addr_c;
	logic o_wr_en_b;
	logic o_wr_en_c;
	logic [ROW_BITS-1:0] o_write_data_b;
	logic [ROW_BITS-1:0] o_write_data_c;
	logic o_core_start;
	logic [WEIGHT_BITS-1:0] o_core_weight;
	logic [2*BUF_BITS-1:0] o_core_fmap;
	logic i_core_valid;
	logic [RESULT_BITS-1:0] i_core_fmap;
	logic o_done;

	// sram contents and the expected copies of b and c
	logic [ROW_BITS-1:0] mem_a [DEPTH];
	logic [ROW_BITS-1:0] mem_b [DEPTH];
	logic [ROW_BITS-1:0] mem_c [DEPTH];
	logic [ROW_BITS-1:0] exp_b [DEPTH];
	logic [ROW_BITS-1:0] exp_c [DEPTH];
	// address seen by each sram on the last edge
	logic [addr_len-1:0] pend_a;
	logic [addr_len-1:0] pend_b;
	logic [addr_len-1:0] pend_c;
	logic [31:0] lfsr = 32'h6888;
	int ncyc = 0;
	int n_core_start = 0;
	int n_done = 0;
	int value_errs = 0;
	int other_errs = 0;
	int run_cycles = 0;

	tb_clock #(.PERIOD(20), .RESET_CYCLES(RESET_CYCLES)) u_clock (
		.o_clk  (i_clk),
		.o_rstn (i_rstn)
	);

	mat_ops dut0 (.*);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		// galois form, taps 32 22 2 1
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one lfsr step per bit
	task automatic rand_bits(input int n, output logic [127:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v[i] = lfsr[0];
		end
	endtask

	task automatic refill_srams();
		logic [127:0] v;
		for (int a = 0; a < DEPTH; a++) begin
			rand_bits(ROW_BITS, v);
			mem_a[a] = v[ROW_BITS-1:0];
			rand_bits(ROW_BITS, v);
			mem_b[a] = v[ROW_BITS-1:0];
			exp_b[a] = v[ROW_BITS-1:0];
			rand_bits(ROW_BITS, v);
			mem_c[a] = v[ROW_BITS-1:0];
			exp_c[a] = v[ROW_BITS-1:0];
		end
	endtask

	// registered read, data shows the cycle after its address
	task automatic model_srams();
		i_read_data_a = mem_a[pend_a];
		i_read_data_b = mem_b[pend_b];
		i_read_data_c = mem_c[pend_c];
		if (o_wr_en_b)
			mem_b[o_addr_b] = o_write_data_b;
		if (o_wr_en_c)
			mem_c[o_addr_c] = o_write_data_c;
		pend_a = o_addr_a;
		pend_b = o_addr_b;
		pend_c = o_addr_c;
	endtask

	// outputs are settled mid cycle, inputs change here too
	task automatic step();
		@(negedge i_clk);
		ncyc++;
		model_srams();
		if (o_core_start)
			n_core_start++;
		if (o_done)
			n_done++;
	endtask

	task automatic check_weight(input string name, input logic [WEIGHT_BITS-1:0] got,
		input logic [WEIGHT_BITS-1:0] exp);
		if (got !== exp) begin
			value_errs++;
			$display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_fmap(input string name, input logic [2*BUF_BITS-1:0] got,
		input logic [2*BUF_BITS-1:0] exp);
		if (got !== exp) begin
			value_errs++;
			$display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_row(input string name, input logic [ROW_BITS-1:0] got,
		input logic [ROW_BITS-1:0] exp);
		if (got !== exp) begin
			value_errs++;
			$display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			value_errs++;
			$display("Fail at %0t: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			value_errs++;
			$display("Fail at %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_phase(input string name, input ctrl_state_e got, input ctrl_state_e exp);
		if (got !== exp) begin
			value_errs++;
			$display("Fail at %0t: %s is %s, expected %s", $time, name, got.name(), exp.name());
		end
	endtask

	task automatic run_job(input int job);
		logic [127:0] v;
		logic [WEIGHT_BITS-1:0] exp_weight;
		logic [BUF_BITS-1:0] exp_buf_b;
		logic [BUF_BITS-1:0] exp_buf_c;
		logic [RESULT_BITS-1:0] result;
		logic stray_read;
		logic found;
		int t0;
		int tv;
		int lat;
		int stray_at;

		refill_srams();
		// weight rows keep their lower words, row 0 lowest
		for (int r = 0; r < weight_rows; r++)
			exp_weight[r*KEEP_BITS +: KEEP_BITS] = mem_a[read_a_offset + r][KEEP_BITS-1:0];
		for (int r = 0; r < fmap_rows; r++) begin
			exp_buf_b[r*ROW_BITS +: ROW_BITS] = mem_b[read_b_offset + r];
			exp_buf_c[r*ROW_BITS +: ROW_BITS] = mem_c[read_c_offset + r];
		end
		rand_bits(1, v);
		stray_read = v[0];
		i_start = 1'b1;
		t0 = ncyc;
		found = 1'b0;
		for (int k = 0; k < JOB_CYCLES && !found; k++) begin
			step();
			// second start in the read phase, must be dropped
			i_start = stray_read && (k == 2);
			found = o_core_start;
		end
		if (!found) begin
			other_errs++;
			$display("job %0d: no o_core_start followed i_start", job);
			return;
		end
		check_count("o_core_start delay", ncyc - t0, START_TO_CORE);
		check_weight("o_core_weight", o_core_weight, exp_weight);
		// b upper half, c lower half
		check_fmap("o_core_fmap", o_core_fmap, {exp_buf_b, exp_buf_c});

		// core model, random latency and result
		rand_bits(4, v);
		lat = int'(v[3:0]) + 1;
		rand_bits(4, v);
		stray_at = int'(v[3:0]);
		rand_bits(RESULT_BITS, v);
		result = v[RESULT_BITS-1:0];
		for (int k = 0; k < lat; k++) begin
			step();
			i_start = (k == stray_at) && (k < lat - 1);
		end
		i_core_valid = 1'b1;
		i_core_fmap = result;
		tv = ncyc;
		found = 1'b0;
		for (int k = 0; k < JOB_CYCLES && !found; k++) begin
			step();
			// result only valid with the pulse
			i_core_valid = 1'b0;
			i_core_fmap = ~result;
			found = o_done;
		end
		if (!found) begin
			other_errs++;
			$display("job %0d: no o_done followed i_core_valid", job);
			return;
		end
		check_count("o_done delay", ncyc - tv, VALID_TO_DONE);

		// chunks 0 1 to b, 2 3 to c, top word zero
		for (int k = 0; k < out_chunks_per_sram; k++) begin
			exp_b[write_b_offset + k] = ROW_BITS'(result[k*CHUNK_BITS +: CHUNK_BITS]);
			exp_c[write_c_offset + k] =
				ROW_BITS'(result[(k + out_chunks_per_sram)*CHUNK_BITS +: CHUNK_BITS]);
		end
		step();
		check_phase("u_ctrl.r_state", dut0.u_ctrl.r_state, ctrl_idle);
		// any other changed row is a stray write
		for (int a = 0; a < DEPTH; a++) begin
			check_row($sformatf("mem_b[%0d]", a), mem_b[a], exp_b[a]);
			check_row($sformatf("mem_c[%0d]", a), mem_c[a], exp_c[a]);
		end
	endtask

	initial begin
		i_start = 1'b0;
		i_core_valid = 1'b0;
		i_core_fmap = '0;
		i_read_data_a = '0;
		i_read_data_b = '0;
		i_read_data_c = '0;
		pend_a = '0;
		pend_b = '0;
		pend_c = '0;

		// quiet through reset and just after
		repeat (RESET_CYCLES + 2) begin
			step();
			check_flag("o_done", o_done, 1'b0);
			check_flag("o_core_start", o_core_start, 1'b0);
			check_flag("o_wr_en_b", o_wr_en_b, 1'b0);
			check_flag("o_wr_en_c", o_wr_en_c, 1'b0);
		end
		check_phase("u_ctrl.r_state", dut0.u_ctrl.r_state, ctrl_idle);

		for (int j = 0; j < JOBS; j++)
			run_job(j);

		// stray starts add no jobs
		check_count("o_core_start count", n_core_start, JOBS);
		check_count("o_done count", n_done, JOBS);
		other_errs += dut0.u_checker.n_done_fail + dut0.u_checker.n_wr_fail
			+ dut0.u_checker.n_start_fail;
		$display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	// bound on run length
	always @(posedge i_clk) begin
		run_cycles <= run_cycles + 1;
		if (run_cycles >= CYCLE_LIMIT) begin
			$display("timeout, the jobs did not finish within %0d cycles", CYCLE_LIMIT);
			$display("errors: %0d wrong values, %0d other failures", value_errs, other_errs + 1);
			$display("STATUS: FAIL");
			$finish;
		end
	end

endmodule

//--- mat_ops.f
rtl/mat_ops_pkg.sv
rtl/sram_row_reader.sv
rtl/sram_row_writer.sv
rtl/mat_ops_ctrl.sv
rtl/mat_ops.sv
bench/tb_clock.sv
bench/mat_ops_checker.sv
bench/mat_ops_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mat_ops_tb -f mat_ops.f -o mat_ops_sim
./obj_dir/mat_ops_sim | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation finished without failure"
